// ==== rename_top.f ====
hw/rename_pkg.sv
hw/ckpt_if.sv
hw/branch_buffer.sv
hw/rat_checkpoint.sv
hw/rename_top.sv
tb/tb_clk_gen.sv
tb/rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename stage testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rename_tb -f rename_top.f -o rename_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "No errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb/rename_tb.sv ====
`timescale 1ns/100ps

module rename_tb import rename_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    logic [OPC_W-1:0]  in_opcode;
    logic [PC_W-1:0]   in_pc;
    logic [ARCH_W-1:0] in_rs1;
    logic [ARCH_W-1:0] in_rs2;
    logic [ARCH_W-1:0] in_rd;
    logic [PHYS_W-1:0] in_prd;
    logic              res_valid;
    logic [PC_W-1:0]   res_pc;
    logic              res_mispredict;
    logic              out_valid;
    logic [PHYS_W-1:0] out_prs1;
    logic [PHYS_W-1:0] out_prs2;
    logic              out_is_branch;
    logic [TAG_W-1:0]  out_tag;
    logic              flush;
    logic [TAG_W-1:0]  flush_tag;
    logic [TAG_W:0]    bb_count;

    logic [PHYS_W-1:0] m_map  [NUM_ARCH];            // Model alias table
    logic [PHYS_W-1:0] m_snap [BB_DEPTH][NUM_ARCH];  // Model checkpoints
    logic [PC_W-1:0]   m_pc   [BB_DEPTH];
    logic              m_res  [BB_DEPTH];
    int                m_head;
    int                m_tail;
    int                m_count;
    logic              e_valid;                      // Expected after next edge
    logic [PHYS_W-1:0] e_prs1;
    logic [PHYS_W-1:0] e_prs2;
    logic              e_is_br;
    logic [TAG_W-1:0]  e_tag;
    logic              e_flush;
    logic [TAG_W-1:0]  e_ftag;
    logic [31:0]       seed;

    tb_clk_gen tb_clk_gen_inst (.clk(clk));

    rename_top rename_top_inst (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic ref_is_branch(input logic [OPC_W-1:0] opc);
        return (opc == OPC_BRANCH) || (opc == OPC_JAL) || (opc == OPC_JALR);
    endfunction

    // Age of the oldest unresolved entry holding pc, -1 when none
    function automatic int oldest_match(input logic [PC_W-1:0] pc);
        int slot;
        for (int k = 0; k < m_count; k++) begin
            slot = (m_head + k) % BB_DEPTH;
            if (!m_res[slot] && (m_pc[slot] == pc)) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic ref_ready();
        logic full_stall;
        logic mis_stall;
        full_stall = ref_is_branch(in_opcode) && (m_count == BB_DEPTH);
        mis_stall  = res_valid && res_mispredict && (oldest_match(res_pc) >= 0);
        return !full_stall && !mis_stall;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic model_reset();
        for (int i = 0; i < NUM_ARCH; i++) begin
            m_map[i] = PHYS_W'(i);                   // Arch i on phys i
        end
        for (int s = 0; s < BB_DEPTH; s++) begin
            m_res[s] = 1'b0;
        end
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
        e_valid = 1'b0;
        e_flush = 1'b0;
    endtask

    // Advance the model over the coming rising edge
    task automatic model_step();
        int   ofs;
        int   slot;
        logic accept;
        logic pop;
        ofs     = res_valid ? oldest_match(res_pc) : -1;
        slot    = (m_head + ((ofs < 0) ? 0 : ofs)) % BB_DEPTH;
        accept  = in_valid && ref_ready();
        pop     = (m_count != 0) && m_res[m_head];
        e_valid = accept;
        e_prs1  = m_map[in_rs1];                     // Read before own write
        e_prs2  = m_map[in_rs2];
        e_is_br = ref_is_branch(in_opcode);
        e_tag   = TAG_W'(m_tail);
        e_flush = 1'b0;
        if ((ofs >= 0) && res_mispredict) begin
            e_flush = 1'b1;
            e_ftag  = TAG_W'(slot);
            for (int i = 0; i < NUM_ARCH; i++) begin
                m_map[i] = m_snap[slot][i];
            end
            m_tail  = slot;                          // Drop it and all younger
            m_count = ofs;
        end else begin
            if (accept && (in_rd != '0)) begin
                m_map[in_rd] = in_prd;
            end
            if (accept && e_is_br) begin
                for (int i = 0; i < NUM_ARCH; i++) begin
                    m_snap[m_tail][i] = m_map[i];    // Includes own write
                end
                m_pc[m_tail]  = in_pc;
                m_res[m_tail] = 1'b0;
                m_tail        = (m_tail + 1) % BB_DEPTH;
                m_count++;
            end
            if (ofs >= 0) begin
                m_res[slot] = 1'b1;
            end
        end
        if (pop) begin
            m_res[m_head] = 1'b0;
            m_head        = (m_head + 1) % BB_DEPTH;
            m_count--;
        end
    endtask

    // Inputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (in_ready == ref_ready()) else
                fail_stop($sformatf("** Error at %0t: in_ready is %0b", $time, in_ready));
            assert (bb_count == (TAG_W+1)'(m_count)) else
                fail_stop($sformatf("** Error at %0t: bb_count %0d, expected %0d",
                                    $time, bb_count, m_count));
            assert (out_valid == e_valid) else
                fail_stop($sformatf("** Error at %0t: out_valid is %0b", $time, out_valid));
            if (e_valid) begin
                assert ((out_prs1 == e_prs1) && (out_prs2 == e_prs2)) else
                    fail_stop($sformatf("** Error at %0t: prs %0d/%0d, expected %0d/%0d",
                                        $time, out_prs1, out_prs2, e_prs1, e_prs2));
                assert (out_is_branch == e_is_br) else
                    fail_stop($sformatf("** Error at %0t: out_is_branch is %0b",
                                        $time, out_is_branch));
                if (e_is_br) begin
                    assert (out_tag == e_tag) else
                        fail_stop($sformatf("** Error at %0t: out_tag %0d, expected %0d",
                                            $time, out_tag, e_tag));
                end
            end
            assert (flush == e_flush) else
                fail_stop($sformatf("** Error at %0t: flush is %0b", $time, flush));
            if (e_flush) begin
                assert (flush_tag == e_ftag) else
                    fail_stop($sformatf("** Error at %0t: flush_tag %0d, expected %0d",
                                        $time, flush_tag, e_ftag));
            end
            model_step();
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;                                      // Drive point after the edge
        end
    endtask

    task automatic send(input logic [OPC_W-1:0] opc, input logic [PC_W-1:0] pc,
                        input logic [ARCH_W-1:0] rs1, input logic [ARCH_W-1:0] rs2,
                        input logic [ARCH_W-1:0] rd, input logic [PHYS_W-1:0] prd);
        int waited;
        in_valid  = 1'b1;
        in_opcode = opc;
        in_pc     = pc;
        in_rs1    = rs1;
        in_rs2    = rs2;
        in_rd     = rd;
        in_prd    = prd;
        waited    = 0;
        @(negedge clk);
        while (!in_ready && (waited < 50)) begin
            waited++;
            @(negedge clk);
        end
        if (!in_ready) begin
            fail_stop("in_ready stuck low");
        end
        wait_cycles(1);
        in_valid = 1'b0;
    endtask

    task automatic send_alu(input logic no_write);
        logic [31:0]      r;
        logic [OPC_W-1:0] opc;
        r = lcg_next();
        case (r[9:8])
            2'd0:    opc = 7'b0110011;               // OP
            2'd1:    opc = 7'b0010011;               // OP-IMM
            2'd2:    opc = 7'b0000011;               // LOAD
            default: opc = 7'b0110111;               // LUI
        endcase
        send(opc, r, r[31:27], r[26:22], no_write ? '0 : r[21:17], r[16:11]);
    endtask

    task automatic send_branch(input logic [PC_W-1:0] pc);
        logic [31:0]      r;
        logic [OPC_W-1:0] opc;
        r   = lcg_next();
        opc = (r[9:8] == 2'd0) ? OPC_JAL : ((r[9:8] == 2'd1) ? OPC_JALR : OPC_BRANCH);
        send(opc, pc, r[31:27], r[26:22], r[21:17], r[16:11]);
    endtask

    task automatic sweep_map();
        for (int k = 0; k < NUM_ARCH / 2; k++) begin
            send(7'b0110011, '0, ARCH_W'(2 * k), ARCH_W'(2 * k + 1), '0, '0);
        end
    endtask

    task automatic resolve(input logic [PC_W-1:0] pc, input logic mis);
        res_valid      = 1'b1;
        res_pc         = pc;
        res_mispredict = mis;
        wait_cycles(1);
        res_valid      = 1'b0;
        res_mispredict = 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_opcode      = '0;
        in_pc          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_rd          = '0;
        in_prd         = '0;
        res_valid      = 1'b0;
        res_pc         = '0;
        res_mispredict = 1'b0;
        seed           = 32'd21;
        model_reset();
        wait_cycles(4);
        rst = 1'b0;
        sweep_map();                                 // Identity map after reset
        repeat (40) send_alu(1'b0);
        repeat (4) send_alu(1'b1);                   // x0 destinations
        for (int k = 0; k < BB_DEPTH; k++) begin
            send_branch(32'h1000 + 32'(4 * k));      // Tags 0..7
        end
        fork
            send_branch(32'h1020);                   // Held off by a full buffer
            begin
                wait_cycles(3);
                resolve(32'h1000, 1'b0);
            end
        join
        resolve(32'h1008, 1'b0);                     // Younger first, no retire
        wait_cycles(2);
        resolve(32'h1004, 1'b0);
        wait_cycles(3);
        repeat (6) send_alu(1'b0);
        resolve(32'hdead_0000, 1'b1);                // No match, ignored
        resolve(32'h1014, 1'b1);                     // Tag 5 mispredicted
        sweep_map();
        repeat (10) send_alu(1'b0);
        send_branch(32'h2000);                       // Reuses tag 5
        resolve(32'h100c, 1'b0);
        resolve(32'h1010, 1'b0);
        resolve(32'h2000, 1'b0);
        wait_cycles(4);
        if ((bb_count == '0) && (m_count == 0)) begin
            $display("No errors");
            $finish;
        end else begin
            fail_stop("branch buffer not empty at end of test");
        end
    end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;        // 40 ns period
        end
    end

endmodule

// ==== hw/rename_top.sv ====
`timescale 1ns/100ps

module rename_top import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [OPC_W-1:0]  in_opcode,
    input  logic [PC_W-1:0]   in_pc,
    input  logic [ARCH_W-1:0] in_rs1,
    input  logic [ARCH_W-1:0] in_rs2,
    input  logic [ARCH_W-1:0] in_rd,
    input  logic [PHYS_W-1:0] in_prd,
    input  logic              res_valid,
    input  logic [PC_W-1:0]   res_pc,
    input  logic              res_mispredict,
    output logic              out_valid,
    output logic [PHYS_W-1:0] out_prs1,
    output logic [PHYS_W-1:0] out_prs2,
    output logic              out_is_branch,
    output logic [TAG_W-1:0]  out_tag,
    output logic              flush,
    output logic [TAG_W-1:0]  flush_tag,
    output logic [TAG_W:0]    bb_count
);

    logic             accept;
    logic             is_branch;
    logic [TAG_W-1:0] alloc_tag;    // Tail slot from the buffer

    ckpt_if ckpt ();                // Snapshot/restore commands

    assign accept    = in_valid && in_ready;
    assign is_branch = is_ctrl(in_opcode);

    branch_buffer branch_buffer_inst (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_opcode      (in_opcode),
        .in_pc          (in_pc),
        .in_ready       (in_ready),
        .res_valid      (res_valid),
        .res_pc         (res_pc),
        .res_mispredict (res_mispredict),
        .ckpt           (ckpt.branch_buffer),
        .alloc_tag      (alloc_tag),
        .flush          (flush),
        .flush_tag      (flush_tag),
        .bb_count       (bb_count)
    );

    rat_checkpoint rat_checkpoint_inst (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .is_branch     (is_branch),
        .tag           (alloc_tag),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_rd         (in_rd),
        .in_prd        (in_prd),
        .ckpt          (ckpt.rat_checkpoint),
        .out_valid     (out_valid),
        .out_prs1      (out_prs1),
        .out_prs2      (out_prs2),
        .out_is_branch (out_is_branch),
        .out_tag       (out_tag)
    );

endmodule

// ==== hw/rat_checkpoint.sv ====
`timescale 1ns/100ps

module rat_checkpoint import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              accept,      // Transfer this edge
    input  logic              is_branch,
    input  logic [TAG_W-1:0]  tag,         // Slot given to this branch
    input  logic [ARCH_W-1:0] in_rs1,
    input  logic [ARCH_W-1:0] in_rs2,
    input  logic [ARCH_W-1:0] in_rd,
    input  logic [PHYS_W-1:0] in_prd,      // From the free list
    ckpt_if.rat_checkpoint    ckpt,
    output logic              out_valid,
    output logic [PHYS_W-1:0] out_prs1,
    output logic [PHYS_W-1:0] out_prs2,
    output logic              out_is_branch,
    output logic [TAG_W-1:0]  out_tag
);

    map_t map;                      // Live alias table
    map_t map_next;                 // Live table after this cycle's write
    map_t snap_map [BB_DEPTH];      // One copy per branch slot
    logic rd_write;

    assign rd_write = accept && (in_rd != '0); // x0 never remapped

    always_comb begin
        map_next = map;
        if (rd_write) begin
            map_next[in_rd] = in_prd;
        end
    end

    // Snapshot taken from next state so the branch's own dest is in it
    always_ff @(posedge clk) begin
        if (ckpt.snap) begin
            snap_map[ckpt.snap_tag] <= map_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map <= reset_map();
        end else if (ckpt.restore) begin
            map <= snap_map[ckpt.restore_tag]; // Wins, no accept while flushing
        end else begin
            map <= map_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    // Lookups use the map before this instr's write
    always_ff @(posedge clk) begin
        if (accept) begin
            out_prs1      <= map[in_rs1];
            out_prs2      <= map[in_rs2];
            out_is_branch <= is_branch;
            out_tag       <= tag;
        end
    end

endmodule

// ==== hw/branch_buffer.sv ====
`timescale 1ns/100ps

module branch_buffer import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [OPC_W-1:0]  in_opcode,
    input  logic [PC_W-1:0]   in_pc,
    output logic              in_ready,
    input  logic              res_valid,
    input  logic [PC_W-1:0]   res_pc,
    input  logic              res_mispredict,
    ckpt_if.branch_buffer     ckpt,
    output logic [TAG_W-1:0]  alloc_tag,
    output logic              flush,
    output logic [TAG_W-1:0]  flush_tag,
    output logic [TAG_W:0]    bb_count
);

    logic [PC_W-1:0]     pc_q [BB_DEPTH];  // Branch PC per slot
    logic [BB_DEPTH-1:0] resolved;         // Predicted correctly, waiting to retire
    logic [TAG_W-1:0]    head;             // Oldest pending
    logic [TAG_W-1:0]    tail;             // Next free slot
    logic [TAG_W:0]      count;            // 0..8

    logic             in_branch;           // Incoming instr is control transfer
    logic             push;                // Branch accepted this edge
    logic             pop;                 // Head retires this edge
    logic             hit;                 // Resolution matched an entry
    logic [TAG_W-1:0] hit_idx;             // Slot of oldest match
    logic [TAG_W:0]   hit_ofs;             // Distance from head = older entries
    logic [TAG_W-1:0] scan_idx;
    logic             mis_hit;             // Mispredict on a live entry
    logic             ok_hit;              // Correct prediction on a live entry
    logic             full;

    assign in_branch = is_ctrl(in_opcode);
    assign full      = (count == (TAG_W+1)'(BB_DEPTH));

    // Stall on a full buffer or while a flush is being taken
    assign in_ready  = !(in_branch && full) && !mis_hit;
    assign push      = in_valid && in_ready && in_branch;
    assign pop       = (count != '0) && resolved[head];

    // Oldest unresolved entry with a matching PC wins, scan young to old
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        hit_ofs  = '0;
        scan_idx = '0;
        for (int k = BB_DEPTH - 1; k >= 0; k--) begin
            scan_idx = head + TAG_W'(k);
            if (((TAG_W+1)'(k) < count) && !resolved[scan_idx] &&
                (pc_q[scan_idx] == res_pc)) begin
                hit     = 1'b1;
                hit_idx = scan_idx;
                hit_ofs = (TAG_W+1)'(k);
            end
        end
    end

    assign mis_hit = res_valid && res_mispredict && hit;
    assign ok_hit  = res_valid && !res_mispredict && hit;

    // Checkpoint commands, sampled by the RAT at this same edge
    assign ckpt.snap        = push;
    assign ckpt.snap_tag    = tail;
    assign ckpt.restore     = mis_hit;
    assign ckpt.restore_tag = hit_idx;

    assign alloc_tag = tail;                // Tag carried with the renamed instr
    assign bb_count  = count;

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[tail] <= in_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            resolved  <= '0;
            flush     <= 1'b0;
            flush_tag <= '0;
        end else begin
            flush <= mis_hit;               // One cycle pulse
            if (mis_hit) begin
                flush_tag <= hit_idx;
            end
            if (pop) begin
                resolved[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (ok_hit) begin
                resolved[hit_idx] <= 1'b1;
            end
            if (mis_hit) begin
                tail  <= hit_idx;                  // Drop this and younger
                count <= hit_ofs - (TAG_W+1)'(pop); // Head cannot be the match if popping
            end else begin
                if (push) begin
                    resolved[tail] <= 1'b0;
                    tail           <= tail + 1'b1;
                end
                count <= count + (TAG_W+1)'(push) - (TAG_W+1)'(pop);
            end
        end
    end

endmodule

// ==== hw/ckpt_if.sv ====
`timescale 1ns/100ps

interface ckpt_if import rename_pkg::*; ();

    logic             snap;        // Store snapshot this edge
    logic [TAG_W-1:0] snap_tag;    // Slot that owns the snapshot
    logic             restore;     // Reload live map this edge
    logic [TAG_W-1:0] restore_tag; // Slot to reload from

    modport branch_buffer (
        output snap,
        output snap_tag,
        output restore,
        output restore_tag
    );

    modport rat_checkpoint (
        input snap,
        input snap_tag,
        input restore,
        input restore_tag
    );

endinterface

// ==== hw/rename_pkg.sv ====
package rename_pkg;

    localparam int NUM_ARCH = 32;              // Architectural registers
    localparam int ARCH_W   = 5;               // Arch register index width
    localparam int PHYS_W   = 6;               // 64 physical registers
    localparam int BB_DEPTH = 8;               // Branch buffer entries
    localparam int TAG_W    = 3;               // Branch tag width
    localparam int PC_W     = 32;
    localparam int OPC_W    = 7;

    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011; // Conditional branches
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

    // Whole alias table, one physical index per arch register
    typedef logic [NUM_ARCH-1:0][PHYS_W-1:0] map_t;

    // Control transfers get a checkpoint
    function automatic logic is_ctrl(input logic [OPC_W-1:0] opc);
        return (opc == OPC_BRANCH) || (opc == OPC_JAL) || (opc == OPC_JALR);
    endfunction

    // Identity mapping, arch i -> phys i
    function automatic map_t reset_map();
        map_t m;
        for (int i = 0; i < NUM_ARCH; i++) begin
            m[i] = PHYS_W'(i);
        end
        return m;
    endfunction

endpackage
